// File: fetch.f
+incdir+.
fetch_pkg.sv
instr_rom.sv
fetch_stage.sv
prog_loader.sv
if_id_reg.sv
fetch_top.sv
fetch_checker.sv
tb_fetch.sv

// File: Bender.yml
package:
  name: fetch

sources:
  - include_dirs:
      - .
    files:
      - fetch_pkg.sv
      - instr_rom.sv
      - fetch_stage.sv
      - prog_loader.sv
      - if_id_reg.sv
      - fetch_top.sv
      - target: test
        files:
          - fetch_checker.sv
          - tb_fetch.sv

// File: tb_fetch.sv
module tb_fetch;

    timeunit 1ns;
    timeprecision 1ps;

    import fetch_pkg::*;

    typedef enum {OP_PROG_ON, OP_PROG_OFF, OP_LOAD, OP_RUN,
                  OP_BRANCH, OP_JUMP, OP_BOTH, OP_STALL} op_e;

    typedef struct {
        logic [127:0] name;
        op_e          op;
        word_t        a;   // addr, offset, target or cycle count
        word_t        b;   // data or second target
    } entry_t;

    logic         clk;
    logic         rst_n;
    logic         branch;
    word_t        branch_offset;
    logic         jump;
    word_t        jump_target;
    logic         stall;
    logic         prog_mode;
    logic         load_valid;
    logic         load_ready;
    load_addr_t   load_addr;
    word_t        load_data;
    logic         dmem_valid;
    logic         dmem_ready;
    rom_idx_t     dmem_addr;
    word_t        dmem_data;
    logic         id_valid;
    word_t        id_pc;
    word_t        id_link;
    word_t        id_instruction;
    logic [127:0] cur_name;
    int           errors;
    int           checks;
    int           pending;
    int           cycle_count = 0;
    int           cycle_limit = 0;
    int           errs_before;
    entry_t       tests [$];

    fetch_top i_fetch_top (.*);

    fetch_checker i_fetch_checker (.*, .test_name(cur_name));

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // random back-pressure on the data-memory port
    always @(posedge clk) begin
        dmem_ready <= ($urandom % 4) != 0;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count > cycle_limit) begin
            $display("timeout: run went past %0d cycles", cycle_limit);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    task automatic add_entry(input logic [127:0] name, input op_e op,
                             input word_t a, input word_t b);
        entry_t e;
        e.name = name;
        e.op   = op;
        e.a    = a;
        e.b    = b;
        tests.push_back(e);
    endtask

    task automatic apply_entry(input entry_t e);
        case (e.op)
            OP_PROG_ON: begin
                @(posedge clk);
                prog_mode <= 1'b1;
            end
            OP_PROG_OFF: begin
                @(posedge clk);
                prog_mode <= 1'b0;
            end
            OP_LOAD: begin
                @(posedge clk);
                load_valid <= 1'b1;
                load_addr  <= load_addr_t'(e.a);
                load_data  <= e.b;
                do @(posedge clk); while (!load_ready); // wait for the transfer
                load_valid <= 1'b0;
            end
            OP_RUN: repeat (e.a) @(posedge clk);
            OP_BRANCH, OP_JUMP, OP_BOTH: begin
                @(posedge clk);
                branch        <= (e.op != OP_JUMP);
                jump          <= (e.op != OP_BRANCH);
                branch_offset <= e.a;
                jump_target   <= (e.op == OP_BOTH) ? e.b : e.a;
                @(posedge clk);
                branch        <= 1'b0;
                jump          <= 1'b0;
            end
            OP_STALL: begin
                @(posedge clk);
                stall <= 1'b1;
                repeat (e.a) @(posedge clk);
                stall <= 1'b0;
            end
        endcase
    endtask

    initial begin
        void'($urandom(62));
        rst_n         = 1'b0;
        branch        = 1'b0;
        branch_offset = '0;
        jump          = 1'b0;
        jump_target   = '0;
        stall         = 1'b0;
        prog_mode     = 1'b0;
        load_valid    = 1'b0;
        load_addr     = '0;
        load_data     = '0;
        dmem_ready    = 1'b0;
        cur_name      = "reset";

        add_entry("load_prog", OP_PROG_ON, 0, 0);
        for (int i = 0; i < 16; i++) add_entry("load_prog", OP_LOAD, i, $urandom);
        for (int i = 0; i < 6; i++) add_entry("data_split", OP_LOAD, 32'h100 | i, $urandom);
        add_entry("data_split", OP_RUN, 10, 0);    // let the buffer drain
        add_entry("seq_fetch", OP_PROG_OFF, 0, 0);
        add_entry("seq_fetch", OP_RUN, 24, 0);
        add_entry("branch_fwd", OP_BRANCH, 2, 0);
        add_entry("branch_fwd", OP_RUN, 6, 0);
        add_entry("branch_back", OP_BRANCH, -5, 0);
        add_entry("branch_back", OP_RUN, 6, 0);
        add_entry("jump", OP_JUMP, 32'h10, 0);
        add_entry("jump", OP_RUN, 6, 0);
        add_entry("branch_prio", OP_BOTH, 1, 32'h30);
        add_entry("branch_prio", OP_RUN, 6, 0);
        add_entry("stall", OP_STALL, 5, 0);
        add_entry("stall", OP_RUN, 8, 0);
        add_entry("reload", OP_PROG_ON, 0, 0);
        add_entry("reload", OP_LOAD, 32'h104, $urandom);
        add_entry("reload", OP_LOAD, 4, $urandom);  // overwrite one word
        add_entry("reload", OP_LOAD, 32'h1ff, $urandom);
        add_entry("reload", OP_RUN, 6, 0);
        add_entry("reload", OP_PROG_OFF, 0, 0);
        add_entry("reload", OP_RUN, 12, 0);

        foreach (tests[i]) begin                     // budget for the timeout
            cycle_limit += (tests[i].op == OP_RUN || tests[i].op == OP_STALL) ?
                           int'(tests[i].a) : 2;
            cycle_limit += 50;
        end

        repeat (4) @(posedge clk);
        rst_n <= 1'b1;

        foreach (tests[i]) begin
            cur_name    = tests[i].name;
            errs_before = errors;
            apply_entry(tests[i]);
            @(negedge clk);                          // checker has settled
            if (errors == errs_before) begin
                $display("%0s: ok", tests[i].name);
            end else begin
                $display("%0s: %0d mismatches", tests[i].name, errors - errs_before);
            end
        end

        repeat (20) @(posedge clk);
        @(negedge clk);
        if (pending != 0) begin
            $display("%0d data words never reached the dmem port", pending);
        end
        $display("tests %0d, checks %0d, errors %0d", tests.size(), checks, errors);
        if (errors == 0 && pending == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// File: fetch_checker.sv
`include "fetch_macros.svh"

module fetch_checker (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  stall,
    input  logic                  prog_mode,
    input  logic                  branch,
    input  logic                  jump,
    input  fetch_pkg::word_t      branch_offset,
    input  fetch_pkg::word_t      jump_target,
    input  logic                  load_valid,
    input  logic                  load_ready,
    input  fetch_pkg::load_addr_t load_addr,
    input  fetch_pkg::word_t      load_data,
    input  logic                  dmem_valid,
    input  logic                  dmem_ready,
    input  fetch_pkg::rom_idx_t   dmem_addr,
    input  fetch_pkg::word_t      dmem_data,
    input  logic                  id_valid,
    input  fetch_pkg::word_t      id_pc,
    input  fetch_pkg::word_t      id_link,
    input  fetch_pkg::word_t      id_instruction,
    input  logic [127:0]          test_name,   // current table entry
    output int                    errors,
    output int                    checks,
    output int                    pending      // data words not yet seen on dmem
);

    timeunit 1ns;
    timeprecision 1ps;

    import fetch_pkg::*;

    word_t    m_mem [`ROM_DEPTH]; // rom contents as loaded
    word_t    m_pc;               // model fetch pc
    word_t    nxt_pc;
    pc_sel_e  sel;
    logic     m_no_op;            // fetch word is a bubble
    logic     m_pmq;              // prog_mode one cycle back
    logic     exp_valid;          // expected id outputs
    word_t    exp_pc;
    word_t    exp_link;
    word_t    exp_instr;
    word_t    q_data [$];         // data words in load order
    rom_idx_t q_addr [$];

    initial begin
        for (int i = 0; i < `ROM_DEPTH; i++) begin
            m_mem[i] = '0;
        end
        errors    = 0;
        checks    = 0;
        pending   = 0;
        exp_valid = 1'b0;
    end

    task automatic check_word(input string what, input word_t expv, input word_t actv);
        checks++;
        if (expv !== actv) begin
            errors++;
            $display("Fail %0s %0s expected %h actual %h", test_name, what, expv, actv);
        end
    endtask

    always @(posedge clk) begin
        // compare pre-edge dut state with the model
        if (rst_n) begin
            check_word("id_valid", word_t'(exp_valid), word_t'(id_valid));
            if (exp_valid && id_valid) begin
                check_word("id_pc", exp_pc, id_pc);
                check_word("id_link", exp_link, id_link);
                check_word("id_instruction", exp_instr, id_instruction);
            end
            if (!prog_mode && load_ready) begin
                errors++;
                $display("load_ready was high outside program mode in %0s", test_name);
            end
            if (dmem_valid && dmem_ready) begin // dmem transfer
                if (q_data.size() == 0) begin
                    errors++;
                    $display("unexpected write on the dmem port in %0s", test_name);
                end else begin
                    check_word("dmem_addr", word_t'(q_addr[0]), word_t'(dmem_addr));
                    check_word("dmem_data", q_data[0], dmem_data);
                    void'(q_addr.pop_front());
                    void'(q_data.pop_front());
                end
            end
        end

        // step the model
        if (!rst_n) begin
            m_pc      = '0;
            m_no_op   = 1'b0;
            m_pmq     = 1'b0;
            exp_valid = 1'b0;
        end else begin
            if (!stall) begin // if/id captures unless stalled
                exp_valid = ~m_no_op;
                exp_pc    = m_pc;
                exp_link  = m_pc + 32'd4;
                exp_instr = m_mem[m_pc[`ROM_ADDR_BITS+1:2]];
            end
            sel = branch ? PC_BRANCH : (jump ? PC_JUMP : PC_SEQ); // branch first
            if (m_pmq && !prog_mode) begin
                nxt_pc = '0;                // program mode just left
            end else if (prog_mode || stall) begin
                nxt_pc = m_pc;
            end else begin
                case (sel)
                    PC_BRANCH: nxt_pc = m_pc + 32'd4 + branch_offset * 4;
                    PC_JUMP:   nxt_pc = jump_target;
                    default:   nxt_pc = m_pc + 32'd4;
                endcase
            end
            m_pc    = nxt_pc;
            m_no_op = prog_mode;
            m_pmq   = prog_mode;
            if (load_valid && load_ready) begin // accepted load word
                if (load_addr[`LOAD_ADDR_BITS-1]) begin
                    q_addr.push_back(rom_idx_t'(load_addr[`ROM_ADDR_BITS-1:0]));
                    q_data.push_back(load_data);
                end else begin
                    m_mem[load_addr[`ROM_ADDR_BITS-1:0]] = load_data; // after the read
                end
            end
        end
        pending = q_data.size();
    end

endmodule

// File: fetch_top.sv
module fetch_top (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  branch,         // from ex
    input  fetch_pkg::word_t      branch_offset,
    input  logic                  jump,           // from ex
    input  fetch_pkg::word_t      jump_target,
    input  logic                  stall,          // from hazard unit
    input  logic                  prog_mode,      // high while loading
    input  logic                  load_valid,     // load stream
    output logic                  load_ready,
    input  fetch_pkg::load_addr_t load_addr,
    input  fetch_pkg::word_t      load_data,
    output logic                  dmem_valid,     // data memory write port
    input  logic                  dmem_ready,
    output fetch_pkg::rom_idx_t   dmem_addr,
    output fetch_pkg::word_t      dmem_data,
    output logic                  id_valid,       // decode side
    output fetch_pkg::word_t      id_pc,
    output fetch_pkg::word_t      id_link,
    output fetch_pkg::word_t      id_instruction
);

    import fetch_pkg::*;

    logic     imem_we;     // loader -> rom write
    rom_idx_t imem_idx;
    word_t    imem_wdata;
    word_t    pc;          // fetch -> if/id
    word_t    instruction;
    logic     no_op;

    prog_loader i_prog_loader (
        .clk        (clk),
        .rst_n      (rst_n),
        .prog_mode  (prog_mode),
        .load_valid (load_valid),
        .load_ready (load_ready),
        .load_addr  (load_addr),
        .load_data  (load_data),
        .imem_we    (imem_we),
        .imem_idx   (imem_idx),
        .imem_wdata (imem_wdata),
        .dmem_valid (dmem_valid),
        .dmem_ready (dmem_ready),
        .dmem_addr  (dmem_addr),
        .dmem_data  (dmem_data)
    );

    fetch_stage i_fetch_stage (
        .clk           (clk),
        .rst_n         (rst_n),
        .stall         (stall),
        .prog_mode     (prog_mode),
        .branch        (branch),
        .jump          (jump),
        .branch_offset (branch_offset),
        .jump_target   (jump_target),
        .imem_we       (imem_we),
        .imem_idx      (imem_idx),
        .imem_wdata    (imem_wdata),
        .pc            (pc),
        .instruction   (instruction),
        .no_op         (no_op)
    );

    if_id_reg i_if_id_reg (
        .clk            (clk),
        .rst_n          (rst_n),
        .stall          (stall),
        .no_op          (no_op),
        .pc             (pc),
        .instruction    (instruction),
        .id_valid       (id_valid),
        .id_pc          (id_pc),
        .id_link        (id_link),
        .id_instruction (id_instruction)
    );

endmodule

// File: if_id_reg.sv
module if_id_reg (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             stall,          // hold everything
    input  logic             no_op,          // fetch output is a bubble
    input  fetch_pkg::word_t pc,
    input  fetch_pkg::word_t instruction,
    output logic             id_valid,
    output fetch_pkg::word_t id_pc,
    output fetch_pkg::word_t id_link,        // return address for jal
    output fetch_pkg::word_t id_instruction
);

    import fetch_pkg::*;

    // valid flag
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            id_valid <= 1'b0;
        end else if (!stall) begin
            id_valid <= ~no_op;   // bubble clears it
        end
    end

    // payload, held on stall
    always_ff @(posedge clk) begin
        if (!stall) begin
            id_pc          <= pc;
            id_link        <= pc + word_t'(4);             // delay slot excluded, isa style
            id_instruction <= no_op ? '0 : instruction;    // all-zero word is a nop
        end
    end

endmodule

// File: prog_loader.sv
`include "fetch_macros.svh"

module prog_loader (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  prog_mode,  // loading allowed
    input  logic                  load_valid,
    output logic                  load_ready,
    input  fetch_pkg::load_addr_t load_addr,  // msb selects region
    input  fetch_pkg::word_t      load_data,
    output logic                  imem_we,    // one-cycle rom write
    output fetch_pkg::rom_idx_t   imem_idx,
    output fetch_pkg::word_t      imem_wdata,
    output logic                  dmem_valid, // buffer full
    input  logic                  dmem_ready,
    output fetch_pkg::rom_idx_t   dmem_addr,
    output fetch_pkg::word_t      dmem_data
);

    import fetch_pkg::*;

    logic accept;   // load stream transfer this cycle
    logic is_data;  // word targets data memory
    logic buf_load; // data word enters the buffer

    // buffer takes a new word when empty or draining this cycle
    assign load_ready = prog_mode & (~dmem_valid | dmem_ready);
    assign accept     = load_valid & load_ready;
    assign is_data    = load_addr[`LOAD_ADDR_BITS-1];
    assign buf_load   = accept & is_data;

    // instruction region goes straight to the rom port
    assign imem_we    = accept & ~is_data;
    assign imem_idx   = rom_idx_t'(load_addr[`ROM_ADDR_BITS-1:0]);
    assign imem_wdata = load_data;

    // one-entry data buffer, valid flag
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            dmem_valid <= 1'b0;
        end else if (buf_load) begin
            dmem_valid <= 1'b1;   // refill, also covers drain + refill
        end else if (dmem_ready) begin
            dmem_valid <= 1'b0;   // drained
        end
    end

    // buffer payload
    always_ff @(posedge clk) begin
        if (buf_load) begin
            dmem_addr <= rom_idx_t'(load_addr[`ROM_ADDR_BITS-1:0]); // region bit dropped
            dmem_data <= load_data;
        end
    end

endmodule

// File: fetch_stage.sv
`include "fetch_macros.svh"

module fetch_stage (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                stall,         // from hazard unit
    input  logic                prog_mode,     // loader owns the rom
    input  logic                branch,        // from ex, relative branch taken
    input  logic                jump,          // from ex, register jump
    input  fetch_pkg::word_t    branch_offset, // word offset
    input  fetch_pkg::word_t    jump_target,   // byte address
    input  logic                imem_we,       // loader write into rom
    input  fetch_pkg::rom_idx_t imem_idx,
    input  fetch_pkg::word_t    imem_wdata,
    output fetch_pkg::word_t    pc,
    output fetch_pkg::word_t    instruction,   // always mem[pc]
    output logic                no_op          // fetched word is a bubble
);

    import fetch_pkg::*;

    pc_sel_e  pc_sel;
    word_t    pc_next;     // value pc takes on the next edge
    logic     prog_mode_q; // last cycle's prog_mode
    logic     restart;     // program mode just ended
    logic     hold;
    logic     rom_en;
    rom_idx_t rom_idx;

    assign restart = prog_mode_q & ~prog_mode;
    assign hold    = prog_mode | (stall & ~restart); // restart beats a stall

    // branch wins over jump
    always_comb begin
        if (branch) begin
            pc_sel = PC_BRANCH;
        end else if (jump) begin
            pc_sel = PC_JUMP;
        end else begin
            pc_sel = PC_SEQ;
        end
    end

    always_comb begin
        if (!rst_n) begin
            pc_next = '0;             // rom reads word 0 during reset
        end else if (restart) begin
            pc_next = '0;             // new program starts at 0
        end else if (hold) begin
            pc_next = pc;             // frozen
        end else begin
            case (pc_sel)
                PC_BRANCH: pc_next = pc + word_t'(4) + (branch_offset << 2);
                PC_JUMP:   pc_next = jump_target;
                default:   pc_next = pc + word_t'(4);
            endcase
        end
    end

    // rom is read ahead with pc_next, so rdata lines up with pc
    assign rom_idx = prog_mode ? imem_idx : rom_idx_t'(pc_next[`ROM_ADDR_BITS+1:2]);
    assign rom_en  = ~hold | imem_we | ~rst_n;

    instr_rom i_instr_rom (
        .clk   (clk),
        .en    (rom_en),
        .we    (imem_we & prog_mode), // writes only while loading
        .idx   (rom_idx),
        .wdata (imem_wdata),
        .rdata (instruction)
    );

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc          <= '0;
            no_op       <= 1'b0;
            prog_mode_q <= 1'b0;
        end else begin
            pc          <= pc_next;
            prog_mode_q <= prog_mode;
            no_op       <= prog_mode; // stalled word stays live for if/id
        end
    end

endmodule

// File: instr_rom.sv
`include "fetch_macros.svh"

module instr_rom (
    input  logic                clk,
    input  logic                en,    // port enable, read and write
    input  logic                we,    // write strobe, qualified by en
    input  fetch_pkg::rom_idx_t idx,   // word index
    input  fetch_pkg::word_t    wdata,
    output fetch_pkg::word_t    rdata  // registered read data
);

    import fetch_pkg::*;

    // zero initial contents, the array itself has no reset
    word_t mem [`ROM_DEPTH] = '{default: '0};

    // single port, read returns the old word on a write
    always_ff @(posedge clk) begin
        if (en) begin
            if (we) begin
                mem[idx] <= wdata;     // loader write
            end
            rdata <= mem[idx];         // registered read
        end
    end                                // en low keeps rdata

endmodule

// File: fetch_pkg.sv
`include "fetch_macros.svh"

package fetch_pkg;

    // instruction / pc / data word
    typedef logic [`ISA_WIDTH-1:0] word_t;

    // word index into the instruction rom
    typedef logic [`ROM_ADDR_BITS-1:0] rom_idx_t;

    // loader address, region bit on top
    typedef logic [`LOAD_ADDR_BITS-1:0] load_addr_t;

    // source of the next pc
    typedef enum logic [1:0] {
        PC_SEQ    = 2'd0, // pc + 4
        PC_BRANCH = 2'd1, // pc + 4 + offset * 4
        PC_JUMP   = 2'd2  // absolute register target
    } pc_sel_e;

endpackage

// File: fetch_macros.svh
`ifndef FETCH_MACROS_SVH
`define FETCH_MACROS_SVH

// instruction, pc and data word width in bits
`define ISA_WIDTH 32

// instruction rom word index bits
`define ROM_ADDR_BITS 8

// number of words in the instruction rom
`define ROM_DEPTH (1 << `ROM_ADDR_BITS)

// loader word address, msb picks the region
// msb clear goes to instruction rom, msb set goes to data memory
`define LOAD_ADDR_BITS (`ROM_ADDR_BITS + 1)

`endif
